// ==== list.f ====
hw/beam_cfg_pkg.sv
hw/beam_tag_pkg.sv
hw/rbg_tracker.sv
hw/beam_power_calc.sv
hw/rbg_power_store.sv
hw/beam_power_top.sv
test/tb_beam_power.sv

// ==== Makefile ====
# Verilator build and run of the beam power testbench

VERILATOR ?= verilator
TOP       ?= tb_beam_power
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_MSG  ?= Regression passed

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# pass or fail is taken from the simulator output
run: $(BIN)
	@out="$$($(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_beam_power.sv ====
/*
  testbench for beam_power_top with four beams, shift 8, 64 store entries
  stimulus, gaps, lengths and size codes come from a seeded 32-bit LFSR
  symbols stay well below 64 RBGs so every written entry is read back
*/
`timescale 1ns/100ps

module tb_beam_power;

    import beam_cfg_pkg::*;
    import beam_tag_pkg::*;

    localparam int          NB      = 4;
    localparam int          SHIFT   = 8;
    localparam int          DEPTH   = 64;
    localparam int          NUM_SYM = 8;
    localparam logic [31:0] SEED    = 32'h89fb_9f3c;

    typedef power_t [NB-1:0] pwr_vec_t;

    logic             i_clk;
    logic             i_arst_n;
    logic             i_re_vld;
    logic             i_re_sop;
    logic             i_re_eop;
    sample_t [NB-1:0] i_re_i;
    sample_t [NB-1:0] i_re_q;
    rbg_size_t        i_rbg_size;
    rbg_idx_t         i_rd_addr;
    pwr_vec_t         o_rd_pwr;
    logic             o_pwr_vld;
    rbg_power_tag_s   o_pwr_tag;
    pwr_vec_t         o_pwr;

    logic [31:0] lfsr;
    int unsigned cyc       = 0;
    int unsigned total_res = 0;
    logic        mon_en    = 1'b0;

    // expected results in order of closing
    int unsigned    exp_cyc [$];
    rbg_power_tag_s exp_tag [$];
    pwr_vec_t       exp_pwr [$];

    // power map of the symbol in flight
    pwr_vec_t  sym_map  [DEPTH];
    rbg_size_t sym_code [NUM_SYM];
    int        sym_len  [NUM_SYM];

    beam_power_top #(
        .NUM_BEAMS   (NB),
        .PWR_SHIFT   (SHIFT),
        .STORE_DEPTH (DEPTH)
    ) DUT (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_re_vld   (i_re_vld),
        .i_re_sop   (i_re_sop),
        .i_re_eop   (i_re_eop),
        .i_re_i     (i_re_i),
        .i_re_q     (i_re_q),
        .i_rbg_size (i_rbg_size),
        .i_rd_addr  (i_rd_addr),
        .o_rd_pwr   (o_rd_pwr),
        .o_pwr_vld  (o_pwr_vld),
        .o_pwr_tag  (o_pwr_tag),
        .o_pwr      (o_pwr)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
    end

    // --------------------
    // random source and model

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // one sample in eight is the most negative value
    function automatic sample_t rand_sample();
        if (lfsr_bits(3) == 0) begin
            return sample_t'({1'b1, {(SAMPLE_W-1){1'b0}}});
        end
        return sample_t'(lfsr_bits(SAMPLE_W));
    endfunction

    // 4, 8 or 16 RBs of 12 REs
    function automatic int group_len(input rbg_size_t code);
        case (code)
            2'd0:    return 4 * 12;
            2'd1:    return 8 * 12;
            default: return 16 * 12;
        endcase
    endfunction

    function automatic power_t shifted_abs(input sample_t s);
        longint v;
        v = longint'(s) >>> SHIFT;
        if (v < 0) begin
            v = -v;
        end
        return power_t'(v);
    endfunction

    // --------------------
    // checks

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pulse(input logic exp, input logic got);
        if (got !== exp) begin
            $display("[FAIL] o_pwr_vld at cycle %0d: expected %h got %h", cyc, exp, got);
            abort_run();
        end
    endtask

    task automatic check_tag(input rbg_power_tag_s exp, input rbg_power_tag_s got);
        if (got !== exp) begin
            $display("[FAIL] o_pwr_tag: expected %h got %h", exp, got);
            abort_run();
        end
    endtask

    task automatic check_power(input int beam, input power_t exp, input power_t got);
        if (got !== exp) begin
            $display("[FAIL] o_pwr[%0d]: expected %h got %h", beam, exp, got);
            abort_run();
        end
    endtask

    task automatic check_read(input int addr, input pwr_vec_t exp, input pwr_vec_t got);
        if (got !== exp) begin
            $display("[FAIL] o_rd_pwr at address %h: expected %h got %h", addr, exp, got);
            abort_run();
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge i_clk) begin : monitor
        logic due;
        due = 1'b0;
        if (mon_en) begin
            due = (exp_cyc.size() != 0) && (exp_cyc[0] == cyc);
            check_pulse(due, o_pwr_vld);
            if (due) begin
                check_tag(exp_tag[0], o_pwr_tag);
                for (int b = 0; b < NB; b++) begin
                    check_power(b, exp_pwr[0][b], o_pwr[b]);
                end
                void'(exp_cyc.pop_front());
                void'(exp_tag.pop_front());
                void'(exp_pwr.pop_front());
            end
        end
    end

    // --------------------
    // stimulus

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic idle_cycle();
        next_cycle();
        i_re_vld = 1'b0;
        i_re_sop = 1'b0;
        i_re_eop = 1'b0;
    endtask

    task automatic send_symbol(input rbg_size_t code, input int len, output int n_rbg);
        int             rlen;
        int             cnt;
        rbg_idx_t       idx;
        pwr_vec_t       acc;
        rbg_power_tag_s tag;
        rlen = group_len(code);
        cnt  = 0;
        idx  = '0;
        acc  = '0;
        for (int e = 0; e < len; e++) begin
            // about one idle cycle in four
            while (lfsr_bits(2) == 0) begin
                idle_cycle();
            end
            next_cycle();
            i_re_vld   = 1'b1;
            i_re_sop   = (e == 0);
            i_re_eop   = (e == len - 1);
            // size code only counts on the sop RE
            i_rbg_size = (e == 0) ? code : rbg_size_t'(lfsr_bits(2));
            for (int b = 0; b < NB; b++) begin
                i_re_i[b] = rand_sample();
                i_re_q[b] = rand_sample();
                acc[b]    = acc[b] + shifted_abs(i_re_i[b]) + shifted_abs(i_re_q[b]);
            end
            cnt++;
            if ((cnt == rlen) || (e == len - 1)) begin
                tag.rbg_idx  = idx;
                tag.sym_last = (e == len - 1);
                exp_cyc.push_back(cyc + 4);
                exp_tag.push_back(tag);
                exp_pwr.push_back(acc);
                if (int'(idx) < DEPTH) begin
                    sym_map[int'(idx)] = acc;
                end
                idx++;
                cnt = 0;
                acc = '0;
            end
        end
        idle_cycle();
        n_rbg = int'(idx);
    endtask

    task automatic drain_results();
        while (exp_cyc.size() != 0) begin
            @(posedge i_clk);
        end
    endtask

    task automatic read_back(input int n_rbg);
        for (int r = 0; r < n_rbg && r < DEPTH; r++) begin
            next_cycle();
            i_rd_addr = rbg_idx_t'(r);
            // word is registered on the next edge
            @(posedge i_clk);
            @(negedge i_clk);
            check_read(r, sym_map[r], o_rd_pwr);
        end
    endtask

    // --------------------
    // main sequence
    initial begin
        int n_rbg;
        i_arst_n   = 1'b0;
        i_re_vld   = 1'b0;
        i_re_sop   = 1'b0;
        i_re_eop   = 1'b0;
        i_re_i     = '0;
        i_re_q     = '0;
        i_rbg_size = '0;
        i_rd_addr  = '0;
        lfsr       = SEED;
        // every size code once, then random ones
        for (int s = 0; s < NUM_SYM; s++) begin
            sym_code[s] = (s < 4) ? rbg_size_t'(s) : rbg_size_t'(lfsr_bits(2));
            sym_len[s]  = 200 + int'(lfsr_bits(9));
            if (s == 4) begin
                sym_len[s] = 3 * group_len(sym_code[s]);
            end
            total_res += sym_len[s];
        end
        repeat (2) @(posedge i_clk);
        // still in reset, o_pwr_vld must stay low from here on
        mon_en = 1'b1;
        repeat (3) @(posedge i_clk);
        #1;
        i_arst_n = 1'b1;
        for (int s = 0; s < NUM_SYM; s++) begin
            send_symbol(sym_code[s], sym_len[s], n_rbg);
            drain_results();
            read_back(n_rbg);
        end
        repeat (4) next_cycle();
        $display("Regression passed");
        $finish;
    end

    // run length follows the planned RE count
    initial begin
        wait (total_res != 0);
        repeat (total_res * 2 + 1000) @(posedge i_clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped producing results", cyc);
        abort_run();
    end

endmodule

// ==== hw/beam_power_top.sv ====
/*
  per-beam RBG power measurement: tracker, calculator, store
  o_pwr_vld pulses 4 cycles after the RE that closes an RBG
  no back-pressure, every o_pwr_vld pulse must be taken
*/
`timescale 1ns/100ps

module beam_power_top #(
    parameter int NUM_BEAMS   = 4,
    parameter int PWR_SHIFT   = 8,
    parameter int STORE_DEPTH = 64
) (
    input  logic                                  i_clk,
    input  logic                                  i_arst_n,
    input  logic                                  i_re_vld,
    input  logic                                  i_re_sop,
    input  logic                                  i_re_eop,
    input  beam_cfg_pkg::sample_t [NUM_BEAMS-1:0] i_re_i,
    input  beam_cfg_pkg::sample_t [NUM_BEAMS-1:0] i_re_q,
    input  beam_cfg_pkg::rbg_size_t               i_rbg_size,
    input  beam_cfg_pkg::rbg_idx_t                i_rd_addr,
    output beam_cfg_pkg::power_t  [NUM_BEAMS-1:0] o_rd_pwr,
    output logic                                  o_pwr_vld,
    output beam_tag_pkg::rbg_power_tag_s          o_pwr_tag,
    output beam_cfg_pkg::power_t  [NUM_BEAMS-1:0] o_pwr
);

    import beam_cfg_pkg::*;
    import beam_tag_pkg::*;

    // tracker to calculator
    logic                    trk_vld;
    re_tag_s                 trk_tag;
    sample_t [NUM_BEAMS-1:0] trk_re_i;
    sample_t [NUM_BEAMS-1:0] trk_re_q;

    // calculator to store and outputs
    logic                    pwr_vld;
    rbg_power_tag_s          pwr_tag;
    power_t  [NUM_BEAMS-1:0] pwr;

    rbg_tracker #(
        .NUM_BEAMS (NUM_BEAMS)
    ) u_tracker (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rbg_size (i_rbg_size),
        .i_re_vld   (i_re_vld),
        .i_re_sop   (i_re_sop),
        .i_re_eop   (i_re_eop),
        .i_re_i     (i_re_i),
        .i_re_q     (i_re_q),
        .o_vld      (trk_vld),
        .o_tag      (trk_tag),
        .o_re_i     (trk_re_i),
        .o_re_q     (trk_re_q)
    );

    beam_power_calc #(
        .NUM_BEAMS (NUM_BEAMS),
        .PWR_SHIFT (PWR_SHIFT)
    ) u_calc (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_vld    (trk_vld),
        .i_tag    (trk_tag),
        .i_re_i   (trk_re_i),
        .i_re_q   (trk_re_q),
        .o_vld    (pwr_vld),
        .o_tag    (pwr_tag),
        .o_pwr    (pwr)
    );

    rbg_power_store #(
        .NUM_BEAMS   (NUM_BEAMS),
        .STORE_DEPTH (STORE_DEPTH)
    ) u_store (
        .i_clk     (i_clk),
        .i_wr_en   (pwr_vld),
        .i_wr_idx  (pwr_tag.rbg_idx),
        .i_wr_pwr  (pwr),
        .i_rd_addr (i_rd_addr),
        .o_rd_pwr  (o_rd_pwr)
    );

    assign o_pwr_vld = pwr_vld;
    assign o_pwr_tag = pwr_tag;
    assign o_pwr     = pwr;

endmodule

// ==== hw/rbg_power_store.sv ====
/*
  power map of one symbol, one word of NUM_BEAMS sums per RBG
  STORE_DEPTH up to 256; writes at or above it are dropped
  no reset, so a word reads as garbage until written
  out-of-range reads return zero
*/
`timescale 1ns/100ps

module rbg_power_store #(
    parameter int NUM_BEAMS   = 4,
    parameter int STORE_DEPTH = 64
) (
    input  logic                                 i_clk,
    input  logic                                 i_wr_en,
    input  beam_cfg_pkg::rbg_idx_t               i_wr_idx,
    input  beam_cfg_pkg::power_t [NUM_BEAMS-1:0] i_wr_pwr,
    input  beam_cfg_pkg::rbg_idx_t               i_rd_addr,
    output beam_cfg_pkg::power_t [NUM_BEAMS-1:0] o_rd_pwr
);

    import beam_cfg_pkg::*;

    localparam int ADDR_W = (STORE_DEPTH > 1) ? $clog2(STORE_DEPTH) : 1;

    power_t [NUM_BEAMS-1:0] mem [STORE_DEPTH];

    logic              wr_ok;
    logic              rd_ok;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // range checks on the full index
    assign wr_ok   = (32'(i_wr_idx) < STORE_DEPTH);
    assign rd_ok   = (32'(i_rd_addr) < STORE_DEPTH);
    assign wr_addr = i_wr_idx[ADDR_W-1:0];
    assign rd_addr = i_rd_addr[ADDR_W-1:0];

    // --------------------
    // write port
    always_ff @(posedge i_clk) begin
        if (i_wr_en && wr_ok) begin
            mem[wr_addr] <= i_wr_pwr;
        end
    end

    // --------------------
    // registered read port
    always_ff @(posedge i_clk) begin
        if (rd_ok) begin
            o_rd_pwr <= mem[rd_addr];
        end else begin
            o_rd_pwr <= '0;
        end
    end

endmodule

// ==== hw/beam_power_calc.sv ====
/*
  per-beam |I|+|Q| after an arithmetic right shift, summed over each RBG
  three register stages; o_vld comes 3 cycles after the rbg_last RE
  sums wrap at 2^POWER_W, no saturation
  o_pwr is only meaningful while o_vld is high
*/
`timescale 1ns/100ps

module beam_power_calc #(
    parameter int NUM_BEAMS = 4,
    parameter int PWR_SHIFT = 8
) (
    input  logic                                  i_clk,
    input  logic                                  i_arst_n,
    input  logic                                  i_vld,
    input  beam_tag_pkg::re_tag_s                 i_tag,
    input  beam_cfg_pkg::sample_t [NUM_BEAMS-1:0] i_re_i,
    input  beam_cfg_pkg::sample_t [NUM_BEAMS-1:0] i_re_q,
    output logic                                  o_vld,
    output beam_tag_pkg::rbg_power_tag_s          o_tag,
    output beam_cfg_pkg::power_t  [NUM_BEAMS-1:0] o_pwr
);

    import beam_cfg_pkg::*;
    import beam_tag_pkg::*;

    // valid and tag follow the data stages
    logic    s1_vld;
    logic    s2_vld;
    re_tag_s s1_tag;
    re_tag_s s2_tag;

    // --------------------
    // control pipeline
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
            o_vld  <= 1'b0;
        end else begin
            s1_vld <= i_vld;
            s2_vld <= s1_vld;
            // sum is complete once the closing RE has been added
            o_vld  <= s2_vld && s2_tag.rbg_last;
        end
    end

    always_ff @(posedge i_clk) begin
        s1_tag <= i_tag;
        s2_tag <= s1_tag;
    end

    // result tag is held for the whole RBG
    always_ff @(posedge i_clk) begin
        if (s2_vld && s2_tag.rbg_last) begin
            o_tag.rbg_idx  <= s2_tag.rbg_idx;
            o_tag.sym_last <= s2_tag.eop;
        end
    end

    // --------------------
    // per-beam datapath
    for (genvar b = 0; b < NUM_BEAMS; b++) begin : g_beam

        sample_t smp_i;
        sample_t smp_q;
        sample_t sft_i;
        sample_t sft_q;
        logic signed [POWER_W-1:0] ext_i;
        logic signed [POWER_W-1:0] ext_q;

        power_t abs_i;
        power_t abs_q;
        power_t mag;
        power_t acc;

        assign smp_i = i_re_i[b];
        assign smp_q = i_re_q[b];

        // arithmetic shift keeps the sign
        assign sft_i = smp_i >>> PWR_SHIFT;
        assign sft_q = smp_q >>> PWR_SHIFT;

        // sign-extend before negation, so the most negative value is safe
        assign ext_i = POWER_W'(sft_i);
        assign ext_q = POWER_W'(sft_q);

        // stage 1: absolute values
        always_ff @(posedge i_clk) begin
            abs_i <= ext_i[POWER_W-1] ? power_t'(-ext_i) : power_t'(ext_i);
            abs_q <= ext_q[POWER_W-1] ? power_t'(-ext_q) : power_t'(ext_q);
        end

        // stage 2: magnitude estimate
        always_ff @(posedge i_clk) begin
            mag <= abs_i + abs_q;
        end

        // stage 3: RBG accumulator
        // first RE loads, gaps hold the running sum
        always_ff @(posedge i_clk) begin
            if (s2_vld) begin
                if (s2_tag.rbg_first) begin
                    acc <= mag;
                end else begin
                    acc <= acc + mag;
                end
            end
        end

        assign o_pwr[b] = acc;

    end

endmodule

// ==== hw/rbg_tracker.sv ====
/*
  cuts a symbol into RBGs and tags every RE
  i_rbg_size is only looked at on the sop RE
  eop closes a short last group; RBG index wraps after 255
*/
`timescale 1ns/100ps

module rbg_tracker #(
    parameter int NUM_BEAMS = 4
) (
    input  logic                                  i_clk,
    input  logic                                  i_arst_n,
    input  beam_cfg_pkg::rbg_size_t               i_rbg_size,
    input  logic                                  i_re_vld,
    input  logic                                  i_re_sop,
    input  logic                                  i_re_eop,
    input  beam_cfg_pkg::sample_t [NUM_BEAMS-1:0] i_re_i,
    input  beam_cfg_pkg::sample_t [NUM_BEAMS-1:0] i_re_q,
    output logic                                  o_vld,
    output beam_tag_pkg::re_tag_s                 o_tag,
    output beam_cfg_pkg::sample_t [NUM_BEAMS-1:0] o_re_i,
    output beam_cfg_pkg::sample_t [NUM_BEAMS-1:0] o_re_q
);

    import beam_cfg_pkg::*;
    import beam_tag_pkg::*;

    re_cnt_t  rbg_len;
    re_cnt_t  re_cnt;
    rbg_idx_t rbg_idx;

    re_cnt_t  cnt_cur;
    re_cnt_t  len_cur;
    rbg_idx_t idx_cur;
    re_tag_s  tag_cur;

    // sop restarts the count on the same RE
    always_comb begin
        cnt_cur = i_re_sop ? '0 : re_cnt;
        len_cur = i_re_sop ? rbg_res_count(i_rbg_size) : rbg_len;
        idx_cur = i_re_sop ? '0 : rbg_idx;

        tag_cur.sop       = i_re_sop;
        tag_cur.rbg_first = (cnt_cur == '0);
        tag_cur.rbg_last  = (cnt_cur == len_cur - re_cnt_t'(1)) || i_re_eop;
        tag_cur.eop       = i_re_eop;
        tag_cur.rbg_idx   = idx_cur;
    end

    // --------------------
    // RE counter and RBG index
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rbg_len <= '0;
            re_cnt  <= '0;
            rbg_idx <= '0;
            o_vld   <= 1'b0;
        end else begin
            o_vld <= i_re_vld;
            if (i_re_vld) begin
                rbg_len <= len_cur;
                if (tag_cur.rbg_last) begin
                    re_cnt  <= '0;
                    rbg_idx <= idx_cur + rbg_idx_t'(1);
                end else begin
                    re_cnt  <= cnt_cur + re_cnt_t'(1);
                    rbg_idx <= idx_cur;
                end
            end
        end
    end

    // samples and tag, qualified by o_vld
    always_ff @(posedge i_clk) begin
        if (i_re_vld) begin
            o_tag  <= tag_cur;
            o_re_i <= i_re_i;
            o_re_q <= i_re_q;
        end
    end

endmodule

// ==== hw/beam_tag_pkg.sv ====
/*
  tags that travel with the data through the power path
  re_tag_s is 12 bits, rbg_power_tag_s is 9 bits
  size codes 2 and 3 both decode to 16 RBs
*/
package beam_tag_pkg;

    import beam_cfg_pkg::*;

    // --------------------
    // per-RE tag
    typedef struct packed {
        logic     sop;        // first RE of the symbol
        logic     rbg_first;  // first RE of an RBG
        logic     rbg_last;   // closing RE of an RBG
        logic     eop;        // last RE of the symbol
        rbg_idx_t rbg_idx;
    } re_tag_s;

    // --------------------
    // per-RBG result tag
    typedef struct packed {
        rbg_idx_t rbg_idx;
        logic     sym_last;   // final RBG of the symbol
    } rbg_power_tag_s;

    // REs per RBG for a size code
    function automatic re_cnt_t rbg_res_count(input rbg_size_t code);
        case (code)
            2'd0:    return re_cnt_t'(48);
            2'd1:    return re_cnt_t'(96);
            default: return re_cnt_t'(192);
        endcase
    endfunction

endpackage

// ==== hw/beam_cfg_pkg.sv ====
/*
  widths and typed vectors for the beam power path
  SAMPLE_W must stay above the shift used in beam_power_calc
  re_cnt_t holds at most 255 REs, enough for a 16 RB group
*/
package beam_cfg_pkg;

    // --------------------
    // widths
    localparam int SAMPLE_W  = 24;
    localparam int POWER_W   = 32;
    localparam int RBG_IDX_W = 8;

    // --------------------
    // typed vectors

    // one I or Q sample, two's complement
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    // |I|+|Q| value or an RBG sum
    typedef logic [POWER_W-1:0] power_t;
    // RBG number within a symbol
    typedef logic [RBG_IDX_W-1:0] rbg_idx_t;
    // size code: 0 -> 4 RB, 1 -> 8 RB, 2/3 -> 16 RB (12 REs per RB)
    typedef logic [1:0] rbg_size_t;
    // RE position inside an RBG
    typedef logic [7:0] re_cnt_t;

endpackage
